/* src/egr_macros.svh */
/*
  Geometry and register map of the egress stage.
  PORT_EN reset value enables every port.
  TX_FRAMES sits at EGR_REG_TX_FRAMES plus 4 per port.
*/
`ifndef EGR_MACROS_SVH
`define EGR_MACROS_SVH

// Switch geometry
`define EGR_NUM_PORTS      4
`define EGR_DATA_W         32
`define EGR_FIFO_DEPTH     16
`define EGR_AXIL_ADDR_W    8
`define EGR_CNT_W          32

// Register offsets
`define EGR_REG_PORT_EN    8'h00
`define EGR_REG_DROP_CNT   8'h04
`define EGR_REG_TX_FRAMES  8'h10
`define EGR_PORT_EN_RST    {`EGR_NUM_PORTS{1'b1}}

// AXI4-Lite response codes
`define EGR_RESP_OKAY      2'b00
`define EGR_RESP_SLVERR    2'b10

`endif

/* src/egr_pkg.sv */
/*
  Shared types of the egress stage.
  Widths come from the macro header.
*/
`default_nettype none

`include "egr_macros.svh"

package egr_pkg;

  // ==========================================================
  // Plain widths
  // ==========================================================
  typedef logic [`EGR_DATA_W-1:0]              egr_data_t;
  typedef logic [$clog2(`EGR_NUM_PORTS)-1:0]   egr_port_t;
  typedef logic [`EGR_NUM_PORTS-1:0]           egr_port_mask_t;
  typedef logic [`EGR_CNT_W-1:0]               egr_cnt_t;
  typedef logic [`EGR_AXIL_ADDR_W-1:0]         egr_axil_addr_t;
  typedef logic [1:0]                          egr_axil_resp_t;

  // ==========================================================
  // Data path buses
  // ==========================================================
  // Ingress word, port only meaningful on sop
  typedef struct packed {
    egr_data_t data;
    egr_port_t port;
    logic      sop;
    logic      eop;
  } egr_word_t;

  // Per-port transmit side
  typedef struct packed {
    logic      valid;
    egr_data_t data;
    logic      sop;
    logic      eop;
  } egr_tx_t;

  // ==========================================================
  // Register bus
  // ==========================================================
  // Manager to subordinate
  typedef struct packed {
    egr_axil_addr_t            awaddr;
    logic                      awvalid;
    egr_data_t                 wdata;
    logic [`EGR_DATA_W/8-1:0]  wstrb;
    logic                      wvalid;
    logic                      bready;
    egr_axil_addr_t            araddr;
    logic                      arvalid;
    logic                      rready;
  } egr_axil_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic           awready;
    logic           wready;
    egr_axil_resp_t bresp;
    logic           bvalid;
    logic           arready;
    egr_data_t      rdata;
    egr_axil_resp_t rresp;
    logic           rvalid;
  } egr_axil_rsp_t;

endpackage

`default_nettype wire

/* src/egr_port_router.sv */
/*
  Steers whole frames to the port queues.
  Target and enable are taken from the sop word only.
  Words outside a frame without sop are discarded silently.
  in_ready is combinational from in_word and the queue full flags.
*/
`timescale 1ns/1ps
`default_nettype none

module egr_port_router (
  input  logic                    egress_clock,
  input  logic                    rst,
  input  egr_pkg::egr_word_t      in_word,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  egr_pkg::egr_port_mask_t port_en,
  output egr_pkg::egr_port_mask_t q_wr,
  output egr_pkg::egr_word_t      q_word,
  input  egr_pkg::egr_port_mask_t q_full,
  output logic                    drop_pulse
);

  typedef enum logic {IDLE, IN_FRAME} rt_state_t;

  rt_state_t          state;
  egr_pkg::egr_port_t frame_port;
  logic               frame_drop;
  egr_pkg::egr_port_t cur_port;
  logic               cur_drop;
  logic               idle;
  logic               fire;

  // ==========================================================
  // Target of the current word
  // ==========================================================
  always_comb begin
    idle = (state == IDLE);
    if (idle) begin
      // Start of frame, decide from the word itself
      cur_port = in_word.port;
      cur_drop = !in_word.sop || !port_en[in_word.port];
    end else begin
      cur_port = frame_port;
      cur_drop = frame_drop;
    end
  end

  // Dropped frames never stall
  assign in_ready = cur_drop || !q_full[cur_port];
  assign fire     = in_valid && in_ready;

  // One strobe per port, shared word bus
  assign q_word = in_word;
  assign q_wr   = (fire && !cur_drop) ? (egr_pkg::egr_port_mask_t'(1) << cur_port) : '0;

  // Counted once per frame
  assign drop_pulse = fire && idle && in_word.sop && cur_drop;

  // ==========================================================
  // Frame tracking FSM
  // ==========================================================
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      state      <= IDLE;
      frame_port <= '0;
      frame_drop <= 1'b0;
    end else if (fire) begin
      case (state)
        IDLE: begin
          // Single word frames stay in IDLE
          if (in_word.sop && !in_word.eop) begin
            state      <= IN_FRAME;
            frame_port <= cur_port;
            frame_drop <= cur_drop;
          end
        end
        IN_FRAME: begin
          if (in_word.eop) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Upstream must open every frame with sop
  a_sop_opens_frame: assert property (@(posedge egress_clock) disable iff (rst)
    (state == IDLE && in_valid) |-> in_word.sop)
    else $error("egr_port_router: word without sop outside a frame");

endmodule

`default_nettype wire

/* src/egr_port_fifo.sv */
/*
  Show-ahead queue for one port.
  Head word drives the tx bus directly, no output register.
  Writes while full are ignored and flagged by an assertion.
*/
`timescale 1ns/1ps
`default_nettype none

`include "egr_macros.svh"

module egr_port_fifo #(
  parameter int DEPTH = `EGR_FIFO_DEPTH
) (
  input  logic               egress_clock,
  input  logic               rst,
  input  logic               wr,
  input  egr_pkg::egr_word_t wr_word,
  output logic               full,
  output egr_pkg::egr_tx_t   tx,
  input  logic               tx_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  egr_pkg::egr_word_t mem [DEPTH];
  egr_pkg::egr_word_t head;
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               wr_en;
  logic               rd;

  // Wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ==========================================================
  // Show-ahead output
  // ==========================================================
  assign head     = mem[rd_ptr];
  assign tx.valid = (count != '0);
  assign tx.data  = head.data;
  assign tx.sop   = head.sop;
  assign tx.eop   = head.eop;

  assign full  = (count == CNT_W'(DEPTH));
  assign wr_en = wr && !full;
  assign rd    = tx.valid && tx_ready;

  // Storage
  always_ff @(posedge egress_clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // Pointers and fill level
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Router must respect full
  a_no_write_full: assert property (@(posedge egress_clock) disable iff (rst)
    wr |-> !full)
    else $error("egr_port_fifo: write while full");

  // Held word under back-pressure
  a_tx_stable: assert property (@(posedge egress_clock) disable iff (rst)
    (tx.valid && !tx_ready) |=> $stable(tx))
    else $error("egr_port_fifo: tx changed while stalled");

endmodule

`default_nettype wire

/* src/egr_csr_axil.sv */
/*
  AXI4-Lite register block, one write and one read at a time.
  Unmapped addresses answer SLVERR, reads of them return zero.
  Counter writes answer OKAY and change nothing.
  Counters are 32 bit and wrap.
*/
`timescale 1ns/1ps
`default_nettype none

`include "egr_macros.svh"

module egr_csr_axil (
  input  logic                    egress_clock,
  input  logic                    rst,
  input  egr_pkg::egr_axil_req_t  axil_req,
  output egr_pkg::egr_axil_rsp_t  axil_rsp,
  output egr_pkg::egr_port_mask_t port_en,
  input  logic                    drop_pulse,
  input  egr_pkg::egr_port_mask_t tx_frame_pulse
);

  typedef enum logic [1:0] {W_IDLE, W_ACK, W_RESP} wr_state_t;
  typedef enum logic [1:0] {R_IDLE, R_ACK, R_DATA} rd_state_t;

  wr_state_t               wr_state;
  rd_state_t               rd_state;
  egr_pkg::egr_cnt_t       drop_cnt;
  egr_pkg::egr_cnt_t       tx_frames [`EGR_NUM_PORTS];
  egr_pkg::egr_axil_resp_t bresp;
  egr_pkg::egr_axil_resp_t rresp;
  egr_pkg::egr_data_t      rdata;
  egr_pkg::egr_data_t      rd_value;
  logic                    rd_ok;

  // ==========================================================
  // Address decode
  // ==========================================================
  // TX_FRAMES window, word aligned
  function automatic logic is_frames_addr(input egr_pkg::egr_axil_addr_t addr);
    return (addr >= `EGR_REG_TX_FRAMES) &&
           (addr < `EGR_REG_TX_FRAMES + 4 * `EGR_NUM_PORTS) &&
           (addr[1:0] == 2'b00);
  endfunction

  function automatic egr_pkg::egr_port_t frames_idx(input egr_pkg::egr_axil_addr_t addr);
    return egr_pkg::egr_port_t'((addr - `EGR_REG_TX_FRAMES) >> 2);
  endfunction

  function automatic logic is_mapped(input egr_pkg::egr_axil_addr_t addr);
    return (addr == `EGR_REG_PORT_EN) || (addr == `EGR_REG_DROP_CNT) ||
           is_frames_addr(addr);
  endfunction

  // Read mux
  always_comb begin
    rd_value = '0;
    rd_ok    = 1'b1;
    if (axil_req.araddr == `EGR_REG_PORT_EN) begin
      rd_value = egr_pkg::egr_data_t'(port_en);
    end else if (axil_req.araddr == `EGR_REG_DROP_CNT) begin
      rd_value = drop_cnt;
    end else if (is_frames_addr(axil_req.araddr)) begin
      rd_value = tx_frames[frames_idx(axil_req.araddr)];
    end else begin
      rd_ok = 1'b0;
    end
  end

  // ==========================================================
  // Write channel
  // ==========================================================
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      wr_state <= W_IDLE;
      port_en  <= `EGR_PORT_EN_RST;
    end else begin
      case (wr_state)
        // Wait for address and data together
        W_IDLE: begin
          if (axil_req.awvalid && axil_req.wvalid) begin
            wr_state <= W_ACK;
          end
        end
        // awready and wready high this cycle
        W_ACK: begin
          wr_state <= W_RESP;
          if (axil_req.awaddr == `EGR_REG_PORT_EN && axil_req.wstrb[0]) begin
            port_en <= axil_req.wdata[`EGR_NUM_PORTS-1:0];
          end
        end
        W_RESP: begin
          if (axil_req.bready) begin
            wr_state <= W_IDLE;
          end
        end
        default: wr_state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge egress_clock) begin
    if (wr_state == W_ACK) begin
      bresp <= is_mapped(axil_req.awaddr) ? `EGR_RESP_OKAY : `EGR_RESP_SLVERR;
    end
  end

  // ==========================================================
  // Read channel
  // ==========================================================
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      rd_state <= R_IDLE;
    end else begin
      case (rd_state)
        R_IDLE: begin
          if (axil_req.arvalid) begin
            rd_state <= R_ACK;
          end
        end
        R_ACK:   rd_state <= R_DATA;
        R_DATA: begin
          if (axil_req.rready) begin
            rd_state <= R_IDLE;
          end
        end
        default: rd_state <= R_IDLE;
      endcase
    end
  end

  // Data captured on the arready cycle
  always_ff @(posedge egress_clock) begin
    if (rd_state == R_ACK) begin
      rdata <= rd_value;
      rresp <= rd_ok ? `EGR_RESP_OKAY : `EGR_RESP_SLVERR;
    end
  end

  // Statistics
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      drop_cnt <= '0;
      for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
        tx_frames[p] <= '0;
      end
    end else begin
      if (drop_pulse) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
      for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
        if (tx_frame_pulse[p]) begin
          tx_frames[p] <= tx_frames[p] + 1'b1;
        end
      end
    end
  end

  // Response bus
  assign axil_rsp.awready = (wr_state == W_ACK);
  assign axil_rsp.wready  = (wr_state == W_ACK);
  assign axil_rsp.bvalid  = (wr_state == W_RESP);
  assign axil_rsp.bresp   = bresp;
  assign axil_rsp.arready = (rd_state == R_ACK);
  assign axil_rsp.rvalid  = (rd_state == R_DATA);
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = rresp;

  // Response held until the manager takes it
  a_bvalid_hold: assert property (@(posedge egress_clock) disable iff (rst)
    (axil_rsp.bvalid && !axil_req.bready) |=> axil_rsp.bvalid)
    else $error("egr_csr_axil: bvalid dropped before bready");

endmodule

`default_nettype wire

/* src/egr_top.sv */
/*
  Egress stage top, router feeding one queue per port.
  Frame counts taken at the tx side on eop words.
  Drop count taken at the router on sop words.
*/
`timescale 1ns/1ps
`default_nettype none

`include "egr_macros.svh"

module egr_top (
  input  logic                    egress_clock,
  input  logic                    rst,
  input  egr_pkg::egr_word_t      in_word,
  input  logic                    in_valid,
  output logic                    in_ready,
  output egr_pkg::egr_tx_t        tx [`EGR_NUM_PORTS],
  input  egr_pkg::egr_port_mask_t tx_ready,
  input  egr_pkg::egr_axil_req_t  axil_req,
  output egr_pkg::egr_axil_rsp_t  axil_rsp
);

  egr_pkg::egr_port_mask_t q_wr;
  egr_pkg::egr_word_t      q_word;
  egr_pkg::egr_port_mask_t q_full;
  egr_pkg::egr_port_mask_t port_en;
  egr_pkg::egr_port_mask_t tx_frame_pulse;
  logic                    drop_pulse;

  // ==========================================================
  // Frame router
  // ==========================================================
  egr_port_router u_router (
     .egress_clock (egress_clock)
    ,.rst          (rst)
    ,.in_word      (in_word)
    ,.in_valid     (in_valid)
    ,.in_ready     (in_ready)
    ,.port_en      (port_en)
    ,.q_wr         (q_wr)
    ,.q_word       (q_word)
    ,.q_full       (q_full)
    ,.drop_pulse   (drop_pulse)
  );

  // ==========================================================
  // Port queues
  // ==========================================================
  for (genvar p = 0; p < `EGR_NUM_PORTS; p++) begin : gen_port
    egr_port_fifo #(
      .DEPTH (`EGR_FIFO_DEPTH)
    ) u_fifo (
       .egress_clock (egress_clock)
      ,.rst          (rst)
      ,.wr           (q_wr[p])
      ,.wr_word      (q_word)
      ,.full         (q_full[p])
      ,.tx           (tx[p])
      ,.tx_ready     (tx_ready[p])
    );

    // Last word of a frame leaving the port
    assign tx_frame_pulse[p] = tx[p].valid && tx_ready[p] && tx[p].eop;
  end

  // Registers and statistics
  egr_csr_axil u_csr (
     .egress_clock   (egress_clock)
    ,.rst            (rst)
    ,.axil_req       (axil_req)
    ,.axil_rsp       (axil_rsp)
    ,.port_en        (port_en)
    ,.drop_pulse     (drop_pulse)
    ,.tx_frame_pulse (tx_frame_pulse)
  );

endmodule

`default_nettype wire

/* bench/egr_tests.svh */
/*
  Directed tests, AXI4-Lite helpers and scoreboard of the egress testbench.
  Included inside the testbench module and uses its signals directly.
  Expected results follow a model of PORT_EN kept by the tests.
*/
`ifndef EGR_TESTS_SVH
`define EGR_TESTS_SVH

  // ==========================================================
  // Scoreboard state
  // ==========================================================
  egr_pkg::egr_tx_t        exp_q [`EGR_NUM_PORTS][$];
  egr_pkg::egr_tx_t        got_q [`EGR_NUM_PORTS][$];
  egr_pkg::egr_cnt_t       exp_frames [`EGR_NUM_PORTS];
  egr_pkg::egr_cnt_t       exp_drops;
  egr_pkg::egr_port_mask_t en_model;

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
    assert (got_v === exp_v) else begin
      $display("ERR t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp_v, got_v);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // Ready pattern and capture for every port
  task automatic run_sinks();
    forever begin
      @(negedge egress_clock);
      for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
        tx_ready[p] = ready_random ? 1'($urandom % 2) : 1'b1;
        // Word leaves at the next rising edge
        if (tx[p].valid && tx_ready[p]) begin
          got_q[p].push_back(tx[p]);
        end
      end
    end
  endtask

  // ==========================================================
  // Bus helpers
  // ==========================================================
  task automatic axil_write(input egr_pkg::egr_axil_addr_t addr, input egr_pkg::egr_data_t data,
                            input logic [3:0] strb, output egr_pkg::egr_axil_resp_t resp);
    @(negedge egress_clock);
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    // Address and data accepted together
    while (!axil_rsp.awready) @(negedge egress_clock);
    compare_value("wready", 1, axil_rsp.wready);
    @(negedge egress_clock);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    while (!axil_rsp.bvalid) @(negedge egress_clock);
    resp = axil_rsp.bresp;
    @(negedge egress_clock);
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input egr_pkg::egr_axil_addr_t addr, output egr_pkg::egr_data_t data,
                           output egr_pkg::egr_axil_resp_t resp);
    @(negedge egress_clock);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    while (!axil_rsp.arready) @(negedge egress_clock);
    @(negedge egress_clock);
    axil_req.arvalid = 1'b0;
    while (!axil_rsp.rvalid) @(negedge egress_clock);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(negedge egress_clock);
    axil_req.rready = 1'b0;
  endtask

  // Enable decided at sop from the mask model
  task automatic send_frame(input egr_pkg::egr_port_t port, input int len);
    egr_pkg::egr_word_t w;
    egr_pkg::egr_tx_t   t;
    logic               deliver;
    deliver = en_model[port];
    if (deliver) begin
      exp_frames[port]++;
    end else begin
      exp_drops++;
    end
    for (int i = 0; i < len; i++) begin
      w.data = $urandom;
      w.port = port;
      w.sop  = (i == 0);
      w.eop  = (i == len - 1);
      @(negedge egress_clock);
      in_word  = w;
      in_valid = 1'b1;
      // in_ready settles inside the low phase
      #1;
      while (!in_ready) begin
        @(negedge egress_clock);
        #1;
      end
      if (deliver) begin
        t.valid = 1'b1;
        t.data  = w.data;
        t.sop   = w.sop;
        t.eop   = w.eop;
        exp_q[port].push_back(t);
      end
    end
    @(negedge egress_clock);
    in_valid = 1'b0;
  endtask

  // ==========================================================
  // Result checks
  // ==========================================================
  task automatic drain_and_compare();
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < 1000) begin
      @(negedge egress_clock);
      waited++;
      done = 1'b1;
      for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
        if (got_q[p].size() < exp_q[p].size()) begin
          done = 1'b0;
        end
      end
    end
    assert (done) else begin
      $display("Ports did not deliver all expected words within %0d cycles", waited);
      err_cnt++;
    end
    // Extra words would show up here
    repeat (20) @(negedge egress_clock);
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      compare_value($sformatf("tx[%0d] word count", p), exp_q[p].size(), got_q[p].size());
      for (int i = 0; i < exp_q[p].size() && i < got_q[p].size(); i++) begin
        assert (got_q[p][i] === exp_q[p][i]) else begin
          $display("ERR t=%0t tx[%0d] word %0d expected 0x%0h got 0x%0h",
                   $time, p, i, exp_q[p][i], got_q[p][i]);
          err_cnt++;
        end
      end
      exp_q[p].delete();
      got_q[p].delete();
    end
  endtask

  task automatic verify_counters();
    egr_pkg::egr_data_t      data;
    egr_pkg::egr_axil_resp_t resp;
    axil_read(`EGR_REG_DROP_CNT, data, resp);
    compare_value("DROP_CNT", exp_drops, data);
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      axil_read(`EGR_REG_TX_FRAMES + 8'(4 * p), data, resp);
      compare_value($sformatf("TX_FRAMES[%0d]", p), exp_frames[p], data);
    end
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================
  task automatic reset_defaults();
    int                      errs;
    egr_pkg::egr_data_t      data;
    egr_pkg::egr_axil_resp_t resp;
    errs = err_cnt;
    @(negedge egress_clock);
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      compare_value($sformatf("tx[%0d].valid", p), 0, tx[p].valid);
    end
    compare_value("in_ready", 1, in_ready);
    compare_value("bvalid", 0, axil_rsp.bvalid);
    compare_value("rvalid", 0, axil_rsp.rvalid);
    axil_read(`EGR_REG_PORT_EN, data, resp);
    compare_value("PORT_EN", 32'hF, data);
    verify_counters();
    report_test("reset_defaults", errs);
  endtask

  task automatic route_each_port();
    int errs;
    errs = err_cnt;
    ready_random = 1'b0;
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      send_frame(egr_pkg::egr_port_t'(p), 1 + int'($urandom % 6));
    end
    drain_and_compare();
    verify_counters();
    report_test("route_each_port", errs);
  endtask

  task automatic random_backpressure();
    int errs;
    errs = err_cnt;
    ready_random = 1'b1;
    repeat (20) begin
      send_frame(egr_pkg::egr_port_t'($urandom % `EGR_NUM_PORTS), 1 + int'($urandom % 6));
    end
    drain_and_compare();
    ready_random = 1'b0;
    verify_counters();
    report_test("random_backpressure", errs);
  endtask

  task automatic disabled_port_drop();
    int                      errs;
    egr_pkg::egr_axil_resp_t resp;
    errs = err_cnt;
    axil_write(`EGR_REG_PORT_EN, 32'h5, 4'hF, resp);
    compare_value("bresp PORT_EN", `EGR_RESP_OKAY, resp);
    en_model = 4'h5;
    for (int i = 0; i < 8; i++) begin
      send_frame(egr_pkg::egr_port_t'(i % `EGR_NUM_PORTS), 1 + int'($urandom % 6));
    end
    drain_and_compare();
    verify_counters();
    // Mask cleared while this frame is in progress
    fork
      send_frame(egr_pkg::egr_port_t'(0), 10);
      begin
        repeat (2) @(negedge egress_clock);
        axil_write(`EGR_REG_PORT_EN, 32'h0, 4'hF, resp);
      end
    join
    en_model = '0;
    drain_and_compare();
    verify_counters();
    axil_write(`EGR_REG_PORT_EN, 32'hF, 4'hF, resp);
    en_model = 4'hF;
    report_test("disabled_port_drop", errs);
  endtask

  task automatic register_errors();
    int                      errs;
    egr_pkg::egr_data_t      data;
    egr_pkg::egr_axil_resp_t resp;
    errs = err_cnt;
    // Hole in the map
    axil_read(8'h08, data, resp);
    compare_value("rresp at 0x08", `EGR_RESP_SLVERR, resp);
    compare_value("rdata at 0x08", 0, data);
    // Counter is read only
    axil_write(`EGR_REG_DROP_CNT, 32'h1234_5678, 4'hF, resp);
    compare_value("bresp DROP_CNT", `EGR_RESP_OKAY, resp);
    axil_read(`EGR_REG_DROP_CNT, data, resp);
    compare_value("DROP_CNT", exp_drops, data);
    // No byte enable, no update
    axil_write(`EGR_REG_PORT_EN, 32'h3, 4'h0, resp);
    compare_value("bresp PORT_EN", `EGR_RESP_OKAY, resp);
    axil_read(`EGR_REG_PORT_EN, data, resp);
    compare_value("PORT_EN", en_model, data);
    report_test("register_errors", errs);
  endtask

`endif

/* bench/egr_tb.sv */
/*
  Testbench top for the egress stage.
  Directed tests and the scoreboard come from the included test file.
  All stimulus changes on the falling clock edge.
  A watchdog ends a stalled run.
*/
`timescale 1ns/1ps
`default_nettype none

`include "egr_macros.svh"

module egr_tb;

  localparam int CLK_PERIOD = 8;
  // Worst case words: 4 x 6, 20 x 6, 8 x 6 and one 10 word frame
  localparam int TOTAL_WORDS = 4 * 6 + 20 * 6 + 8 * 6 + 10;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 20 + 2000;

  logic                    egress_clock;
  logic                    rst;
  egr_pkg::egr_word_t      in_word;
  logic                    in_valid;
  logic                    in_ready;
  egr_pkg::egr_tx_t        tx [`EGR_NUM_PORTS];
  egr_pkg::egr_port_mask_t tx_ready;
  egr_pkg::egr_axil_req_t  axil_req;
  egr_pkg::egr_axil_rsp_t  axil_rsp;

  // Test bookkeeping
  int   pass_cnt;
  int   fail_cnt;
  int   err_cnt;
  logic ready_random;

  // ==========================================================
  // Clock and DUT
  // ==========================================================
  initial egress_clock = 1'b0;
  always #(CLK_PERIOD / 2) egress_clock = ~egress_clock;

  egr_top dut0 (
     .egress_clock (egress_clock)
    ,.rst          (rst)
    ,.in_word      (in_word)
    ,.in_valid     (in_valid)
    ,.in_ready     (in_ready)
    ,.tx           (tx)
    ,.tx_ready     (tx_ready)
    ,.axil_req     (axil_req)
    ,.axil_rsp     (axil_rsp)
  );

  `include "egr_tests.svh"

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    // One seed for the whole run, sinks inherit it through the fork
    void'($urandom(32'h72e6));
    rst          = 1'b1;
    in_word      = '0;
    in_valid     = 1'b0;
    tx_ready     = '1;
    axil_req     = '0;
    ready_random = 1'b0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    err_cnt      = 0;
    // Reference model of the enable mask and counters
    en_model  = '1;
    exp_drops = '0;
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      exp_frames[p] = '0;
    end
    repeat (4) @(posedge egress_clock);
    @(negedge egress_clock);
    rst = 1'b0;
    fork
      run_sinks();
    join_none

    reset_defaults();
    route_each_port();
    random_backpressure();
    disabled_port_drop();
    register_errors();

    $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Sized from the word count of all tests
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
+incdir+bench
src/egr_pkg.sv
src/egr_port_router.sv
src/egr_port_fifo.sv
src/egr_csr_axil.sv
src/egr_top.sv
bench/egr_tb.sv

/* Makefile */
# Verilator simulation of the egress stage

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module egr_tb -f verilog.f -o egr_sim
	./obj_dir/egr_sim | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
